//--- build.f
+incdir+include
hw/ecc_pkg.sv
hw/ecc_syndrome_stage.sv
hw/ecc_correct_stage.sv
hw/ecc_118_cal.sv
testbench/ecc_118_cal_tb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= ecc_118_cal_tb
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := Simulation passed

BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: compile
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- include/ecc_tb_model.svh
`ifndef ECC_TB_MODEL_SVH
`define ECC_TB_MODEL_SVH

localparam int TB_DATA_W = 118;

typedef struct packed {
    logic [TB_DATA_W-1:0] data;
    logic [7:0]           parity;
    logic [TB_DATA_W-1:0] mask;
    logic                 sbit;
    logic                 dbit;
} tb_expect_t;

// Fibonacci LFSR with taps 32 22 2 1
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
endfunction

function automatic logic [7:0] code_column(input int idx);
    int h;
    int n;
    h = 3;
    n = 0;
    while (1) begin
        if ((h & (h - 1)) != 0) begin
            if (n == idx) break;
            n++;
        end
        h++;
    end
    return {~(^h[6:0]), h[6:0]};
endfunction

function automatic logic [7:0] encode_check_bits(input logic [TB_DATA_W-1:0] d);
    logic [7:0] p;
    p = '0;
    for (int i = 0; i < TB_DATA_W; i++) begin
        if (d[i]) p ^= code_column(i);
    end
    return p;
endfunction

function automatic tb_expect_t expected_outputs(input logic [TB_DATA_W-1:0] d,
                                                input logic [7:0] p_in, input logic byp);
    tb_expect_t e;
    logic [7:0] syn;
    e        = '0;
    e.parity = encode_check_bits(d);
    syn      = e.parity ^ p_in;
    if (!byp && syn != 0) begin
        e.dbit = 1'b1;
        if ((syn & (syn - 8'd1)) == 0) begin
            e.sbit = 1'b1;
            e.dbit = 1'b0;
        end
        for (int j = 0; j < TB_DATA_W; j++) begin
            if (syn == code_column(j)) begin
                e.mask[j] = 1'b1;
                e.sbit    = 1'b1;
                e.dbit    = 1'b0;
            end
        end
    end
    e.data = d ^ e.mask;
    return e;
endfunction

`endif

//--- testbench/ecc_118_cal_tb.sv
`timescale 1ns/100ps
`default_nettype none

module ecc_118_cal_tb;

    `include "ecc_tb_model.svh"

    localparam int HS_LIMIT    = 200;  // Cycles to wait for in_ready
    localparam int DRAIN_LIMIT = 500;

    logic                 clk;
    logic                 arst_n;
    logic                 in_valid;
    logic                 in_ready;
    logic [TB_DATA_W-1:0] data_in;
    logic [7:0]           parity_in;
    logic                 bypass;
    logic                 out_valid;
    logic                 out_ready;
    logic [TB_DATA_W-1:0] data_out;
    logic [7:0]           parity_out;
    logic [TB_DATA_W-1:0] mask;
    logic                 sbit_err;
    logic                 dbit_err;

    tb_expect_t           exp_q[$];
    int                   id_q[$];
    logic [TB_DATA_W-1:0] exp_data;
    logic [7:0]           exp_parity;
    logic [TB_DATA_W-1:0] exp_mask;
    logic                 exp_sbit;
    logic                 exp_dbit;
    logic                 have_exp;
    int                   exp_test;
    int                   cur_test;
    int                   errors;
    int                   timeouts;
    logic [31:0]          stim_lfsr;
    logic [31:0]          ready_lfsr;
    logic [127:0]         ready_bits;
    logic                 ready_random;

    ecc_118_cal u_dut (
        .clk        (clk),
        .arst_n     (arst_n),
        .in_valid   (in_valid),
        .in_ready   (in_ready),
        .data_in    (data_in),
        .parity_in  (parity_in),
        .bypass     (bypass),
        .out_valid  (out_valid),
        .out_ready  (out_ready),
        .data_out   (data_out),
        .parity_out (parity_out),
        .mask       (mask),
        .sbit_err   (sbit_err),
        .dbit_err   (dbit_err)
    );

    always #20 clk = ~clk;

    function automatic string test_label(input int id);
        case (id)
            0:       return "reset";
            1:       return "clean";
            2:       return "data_flip";
            3:       return "check_flip";
            4:       return "double_flip";
            5:       return "bypass";
            default: return "backpressure";
        endcase
    endfunction

    // One LFSR step per bit taken with the newest bit at the bottom
    task automatic take_bits(inout logic [31:0] state, input int n, output logic [127:0] bits);
        bits = '0;
        for (int k = 0; k < n; k++) begin
            state = lfsr_next(state);
            bits  = {bits[126:0], state[0]};
        end
    endtask

    task automatic report_mismatch(input int id, input string field,
                                   input logic [TB_DATA_W-1:0] expv,
                                   input logic [TB_DATA_W-1:0] actv);
        errors++;
        $display("CHECK FAILED %s %s: expected %h, actual %h", test_label(id), field, expv, actv);
    endtask

    task automatic send_word(input logic [TB_DATA_W-1:0] d, input logic [7:0] p,
                             input logic byp, input int id);
        int waited;
        waited = 0;
        if (timeouts == 0) begin
            in_valid  <= 1'b1;
            data_in   <= d;
            parity_in <= p;
            bypass    <= byp;
            cur_test  <= id;
            do begin
                @(posedge clk);
                waited++;
            end while (!in_ready && waited < HS_LIMIT);
            if (!in_ready) begin
                timeouts++;
                $display("Timeout: %s word not accepted after %0d cycles", test_label(id), waited);
            end
        end
    endtask

    task automatic drain_outputs();
        int waited;
        waited = 0;
        while (exp_q.size() != 0 && waited < DRAIN_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (exp_q.size() != 0) begin
            timeouts++;
            $display("Timeout: %0d words never came out of the DUT", exp_q.size());
        end
    endtask

    always @(posedge clk) begin
        if (ready_random) begin
            take_bits(ready_lfsr, 1, ready_bits);
            out_ready <= ready_bits[0];
        end else begin
            out_ready <= 1'b1;
        end
    end

    // Scoreboard copies the queue head out for the assertions
    always @(posedge clk) begin
        if (arst_n) begin
            if (out_valid && out_ready && exp_q.size() > 0) begin
                void'(exp_q.pop_front());
                void'(id_q.pop_front());
            end
            if (in_valid && in_ready) begin
                exp_q.push_back(expected_outputs(data_in, parity_in, bypass));
                id_q.push_back(cur_test);
            end
            have_exp = (exp_q.size() > 0);
            if (have_exp) begin
                exp_data   = exp_q[0].data;
                exp_parity = exp_q[0].parity;
                exp_mask   = exp_q[0].mask;
                exp_sbit   = exp_q[0].sbit;
                exp_dbit   = exp_q[0].dbit;
                exp_test   = id_q[0];
            end
        end
    end

    a_expected: assert property (@(posedge clk) disable iff (!arst_n)
        out_valid && out_ready |-> have_exp)
        else begin
            errors++;
            $display("DUT delivered a word that was never sent");
        end

    a_data: assert property (@(posedge clk) disable iff (!arst_n)
        out_valid && out_ready |-> data_out == exp_data)
        else report_mismatch($sampled(exp_test), "data_out", $sampled(exp_data),
                             $sampled(data_out));

    a_parity: assert property (@(posedge clk) disable iff (!arst_n)
        out_valid && out_ready |-> parity_out == exp_parity)
        else report_mismatch($sampled(exp_test), "parity_out",
                             TB_DATA_W'($sampled(exp_parity)),
                             TB_DATA_W'($sampled(parity_out)));

    a_mask: assert property (@(posedge clk) disable iff (!arst_n)
        out_valid && out_ready |-> mask == exp_mask)
        else report_mismatch($sampled(exp_test), "mask", $sampled(exp_mask), $sampled(mask));

    a_flags: assert property (@(posedge clk) disable iff (!arst_n)
        out_valid && out_ready |-> {sbit_err, dbit_err} == {exp_sbit, exp_dbit})
        else report_mismatch($sampled(exp_test), "sbit_dbit",
                             TB_DATA_W'({$sampled(exp_sbit), $sampled(exp_dbit)}),
                             TB_DATA_W'({$sampled(sbit_err), $sampled(dbit_err)}));

    a_hold: assert property (@(posedge clk) disable iff (!arst_n)
        out_valid && !out_ready |=> out_valid && $stable(data_out) && $stable(mask)
            && $stable(parity_out) && $stable({sbit_err, dbit_err}))
        else begin
            errors++;
            $display("Outputs changed while out_ready was low");
        end

    initial begin
        logic [127:0]         r;
        logic [TB_DATA_W-1:0] d;
        logic [TB_DATA_W-1:0] rx;
        logic [7:0]           p;
        int                   a;
        int                   b;
        clk          = 1'b0;
        arst_n       = 1'b0;
        in_valid     = 1'b0;
        data_in      = '0;
        parity_in    = '0;
        bypass       = 1'b0;
        out_ready    = 1'b1;
        ready_random = 1'b0;
        cur_test     = 0;
        exp_test     = 0;
        have_exp     = 1'b0;
        errors       = 0;
        timeouts     = 0;
        stim_lfsr    = 32'h949e4fa8;
        ready_lfsr   = 32'h949e4fa8;
        repeat (5) @(posedge clk);
        arst_n <= 1'b1;
        @(negedge clk);
        assert (!out_valid && in_ready)
            else report_mismatch(0, "out_valid_in_ready", TB_DATA_W'(2'b01),
                                 TB_DATA_W'({out_valid, in_ready}));
        @(posedge clk);

        for (int n = 0; n < 20; n++) begin
            take_bits(stim_lfsr, TB_DATA_W, r);
            d = r[TB_DATA_W-1:0];
            send_word(d, encode_check_bits(d), 1'b0, 1);
        end
        for (int n = 0; n < 30; n++) begin
            take_bits(stim_lfsr, TB_DATA_W, r);
            d = r[TB_DATA_W-1:0];
            take_bits(stim_lfsr, 7, r);
            rx = d;
            rx[int'(r[6:0]) % TB_DATA_W] = ~rx[int'(r[6:0]) % TB_DATA_W];
            send_word(rx, encode_check_bits(d), 1'b0, 2);
        end
        for (int n = 0; n < 16; n++) begin
            take_bits(stim_lfsr, TB_DATA_W, r);
            d = r[TB_DATA_W-1:0];
            p = encode_check_bits(d);
            take_bits(stim_lfsr, 3, r);
            p[r[2:0]] = ~p[r[2:0]];
            send_word(d, p, 1'b0, 3);
        end
        // Positions 0..117 are data bits and 118..125 check bits
        for (int n = 0; n < 30; n++) begin
            take_bits(stim_lfsr, TB_DATA_W, r);
            d  = r[TB_DATA_W-1:0];
            rx = d;
            p  = encode_check_bits(d);
            take_bits(stim_lfsr, 7, r);
            a = int'(r[6:0]) % 126;
            take_bits(stim_lfsr, 7, r);
            b = (a + 1 + int'(r[6:0]) % 125) % 126;
            if (a < TB_DATA_W) rx[a] = ~rx[a];
            else p[a - TB_DATA_W] = ~p[a - TB_DATA_W];
            if (b < TB_DATA_W) rx[b] = ~rx[b];
            else p[b - TB_DATA_W] = ~p[b - TB_DATA_W];
            send_word(rx, p, 1'b0, 4);
        end
        for (int n = 0; n < 20; n++) begin
            take_bits(stim_lfsr, TB_DATA_W, r);
            d = r[TB_DATA_W-1:0];
            p = encode_check_bits(d);
            take_bits(stim_lfsr, TB_DATA_W, r);
            rx = d ^ r[TB_DATA_W-1:0];
            take_bits(stim_lfsr, 8, r);
            send_word(rx, p ^ r[7:0], 1'b1, 5);
        end

        ready_random <= 1'b1;
        for (int n = 0; n < 40; n++) begin
            take_bits(stim_lfsr, TB_DATA_W, r);
            d = r[TB_DATA_W-1:0];
            send_word(d, encode_check_bits(d), 1'b0, 6);
        end
        in_valid <= 1'b0;
        drain_outputs();
        ready_random <= 1'b0;
        assert (exp_q.size() == 0)
            else begin
                errors++;
                $display("Scoreboard still holds %0d words at the end", exp_q.size());
            end

        $display("Errors: %0d check failures, %0d timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- hw/ecc_118_cal.sv
`timescale 1ns/100ps
`default_nettype none

module ecc_118_cal
    import ecc_pkg::*;
#(
    parameter int DATA_WIDTH = 118
) (
    input  wire                    clk,
    input  wire                    arst_n,

    // Upstream
    input  wire                    in_valid,
    output logic                   in_ready,
    input  wire [DATA_WIDTH-1:0]   data_in,
    input  wire ecc_syndrome_t     parity_in,
    input  wire                    bypass,

    // Downstream
    output logic                   out_valid,
    input  wire                    out_ready,
    output logic [DATA_WIDTH-1:0]  data_out,
    output ecc_syndrome_t          parity_out,
    output logic [DATA_WIDTH-1:0]  mask,
    output logic                   sbit_err,
    output logic                   dbit_err
);

    logic                  s1_valid;
    logic                  s1_ready;
    logic [DATA_WIDTH-1:0] s1_data;
    ecc_syndrome_t         s1_parity;
    ecc_syndrome_t         s1_syndrome;
    logic                  s1_bypass;

    // Only 120 non-power-of-two columns fit in 7 index bits
    if (DATA_WIDTH < 1 || DATA_WIDTH > ECC_MAX_DATA_W) begin : g_width_check
        $error("DATA_WIDTH %0d outside 1..%0d", DATA_WIDTH, ECC_MAX_DATA_W);
    end

    ecc_syndrome_stage #(
        .DATA_WIDTH (DATA_WIDTH)
    ) u_syndrome (
        .clk         (clk),
        .arst_n      (arst_n),
        .in_valid    (in_valid),
        .in_ready    (in_ready),
        .data_in     (data_in),
        .parity_in   (parity_in),
        .bypass      (bypass),
        .s1_valid    (s1_valid),
        .s1_ready    (s1_ready),
        .s1_data     (s1_data),
        .s1_parity   (s1_parity),
        .s1_syndrome (s1_syndrome),
        .s1_bypass   (s1_bypass)
    );

    ecc_correct_stage #(
        .DATA_WIDTH (DATA_WIDTH)
    ) u_correct (
        .clk         (clk),
        .arst_n      (arst_n),
        .s1_valid    (s1_valid),
        .s1_ready    (s1_ready),
        .s1_data     (s1_data),
        .s1_parity   (s1_parity),
        .s1_syndrome (s1_syndrome),
        .s1_bypass   (s1_bypass),
        .out_valid   (out_valid),
        .out_ready   (out_ready),
        .data_out    (data_out),
        .parity_out  (parity_out),
        .mask        (mask),
        .sbit_err    (sbit_err),
        .dbit_err    (dbit_err)
    );

endmodule

`default_nettype wire

//--- hw/ecc_correct_stage.sv
`timescale 1ns/100ps
`default_nettype none

module ecc_correct_stage
    import ecc_pkg::*;
#(
    parameter int DATA_WIDTH = 118
) (
    input  wire                    clk,
    input  wire                    arst_n,

    input  wire                    s1_valid,
    output logic                   s1_ready,
    input  wire [DATA_WIDTH-1:0]   s1_data,
    input  wire ecc_syndrome_t     s1_parity,
    input  wire ecc_syndrome_t     s1_syndrome,
    input  wire                    s1_bypass,

    output logic                   out_valid,
    input  wire                    out_ready,
    output logic [DATA_WIDTH-1:0]  data_out,
    output ecc_syndrome_t          parity_out,
    output logic [DATA_WIDTH-1:0]  mask,
    output logic                   sbit_err,
    output logic                   dbit_err
);

    ecc_status_t           status;
    logic [DATA_WIDTH-1:0] mask_c;
    logic                  accept;

    always_comb begin
        status = ECC_OK;
        mask_c = '0;
        if (s1_syndrome != '0) begin
            status = ECC_UNCORRECTABLE;
            if (ecc_is_check_bit(s1_syndrome)) begin
                status = ECC_CORRECTED;  // Check bit only so the data stays untouched
            end
            for (int i = 0; i < DATA_WIDTH; i++) begin
                if (s1_syndrome == ecc_column(i)) begin
                    mask_c[i] = 1'b1;
                    status    = ECC_CORRECTED;
                end
            end
        end
        if (s1_bypass) begin
            status = ECC_OK;
            mask_c = '0;
        end
    end

    assign s1_ready = !out_valid || out_ready;
    assign accept   = s1_valid && s1_ready;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out_valid <= 1'b0;
        end else if (s1_ready) begin
            out_valid <= s1_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            data_out   <= s1_data ^ mask_c;  // Zero mask leaves uncorrectable words as is
            mask       <= mask_c;
            parity_out <= s1_parity;
            sbit_err   <= (status == ECC_CORRECTED);
            dbit_err   <= (status == ECC_UNCORRECTABLE);
        end
    end

    a_flags_exclusive: assert property (
        @(posedge clk) disable iff (!arst_n)
        out_valid |-> !(sbit_err && dbit_err)
    ) else $error("sbit_err and dbit_err both set");

    // At most one mask bit and only on a corrected word
    a_mask_needs_sbit: assert property (
        @(posedge clk) disable iff (!arst_n)
        out_valid |-> (sbit_err ? $onehot0(mask) : (mask == '0))
    ) else $error("mask not one-hot or set without sbit_err");

    a_out_hold: assert property (
        @(posedge clk) disable iff (!arst_n)
        out_valid && !out_ready |=>
            out_valid && $stable({data_out, mask, parity_out, sbit_err, dbit_err})
    ) else $error("outputs changed during stall");

endmodule

`default_nettype wire

//--- hw/ecc_syndrome_stage.sv
`timescale 1ns/100ps
`default_nettype none

module ecc_syndrome_stage
    import ecc_pkg::*;
#(
    parameter int DATA_WIDTH = 118
) (
    input  wire                    clk,
    input  wire                    arst_n,

    input  wire                    in_valid,
    output logic                   in_ready,
    input  wire [DATA_WIDTH-1:0]   data_in,
    input  wire ecc_syndrome_t     parity_in,
    input  wire                    bypass,

    output logic                   s1_valid,
    input  wire                    s1_ready,
    output logic [DATA_WIDTH-1:0]  s1_data,
    output ecc_syndrome_t          s1_parity,
    output ecc_syndrome_t          s1_syndrome,
    output logic                   s1_bypass
);

    ecc_syndrome_t parity;
    logic          accept;

    // Each check bit sums the data bits whose column has that bit set
    always_comb begin
        parity = '0;
        for (int i = 0; i < DATA_WIDTH; i++) begin
            parity = parity ^ (ecc_column(i) & {ECC_PARITY_W{data_in[i]}});
        end
    end

    assign in_ready = !s1_valid || s1_ready;
    assign accept   = in_valid && in_ready;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            s1_valid <= 1'b0;
        end else if (in_ready) begin
            s1_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            s1_data     <= data_in;
            s1_parity   <= parity;
            s1_syndrome <= parity ^ parity_in;
            s1_bypass   <= bypass;
        end
    end

    // Held word must not change until the correct stage takes it
    a_s1_hold: assert property (
        @(posedge clk) disable iff (!arst_n)
        s1_valid && !s1_ready |=>
            s1_valid && $stable({s1_data, s1_parity, s1_syndrome, s1_bypass})
    ) else $error("stage 1 payload changed during stall");

endmodule

`default_nettype wire

//--- hw/ecc_pkg.sv
`default_nettype none

package ecc_pkg;

    localparam int ECC_PARITY_W   = 8;
    localparam int ECC_MAX_DATA_W = 120;

    // Low syndrome bits carry the column index, the top bit makes the weight odd
    localparam int ECC_INDEX_W = ECC_PARITY_W - 1;

    typedef logic [ECC_PARITY_W-1:0] ecc_syndrome_t;

    typedef enum logic [1:0] {
        ECC_OK            = 2'd0,
        ECC_CORRECTED     = 2'd1,  // Single flip in a data or check bit
        ECC_UNCORRECTABLE = 2'd2
    } ecc_status_t;

    function automatic logic ecc_is_pow2(input int unsigned value);
        return (value != 0) && ((value & (value - 1)) == 0);
    endfunction

    // Column of data bit idx; h runs over 3,5,6,7,9,... skipping powers of two
    function automatic ecc_syndrome_t ecc_column(input int unsigned idx);
        logic [ECC_INDEX_W-1:0] h;
        int unsigned            count;
        h     = '0;
        count = 0;
        for (int unsigned v = 3; v < (1 << ECC_INDEX_W); v++) begin
            if (!ecc_is_pow2(v)) begin
                if (count == idx) begin
                    h = v[ECC_INDEX_W-1:0];
                end
                count++;
            end
        end
        return {~(^h), h};  // Even weight index gets the extra one
    endfunction

    // A syndrome with exactly one bit set points at a check bit
    function automatic logic ecc_is_check_bit(input ecc_syndrome_t syn);
        return ecc_is_pow2(int'(syn));
    endfunction

endpackage

`default_nettype wire
